// File: common/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// word and register file geometry
`define WORD_SIZE 16
`define NUM_REGS  4

`define RESET_PC  16'h0000  // first fetch address
`define LINK_REG  2         // return address target of JAL and JRL

`endif

// File: common/isaPkg.sv
package isaPkg;

	// ********************
	// instruction word fields
	typedef enum logic [3:0] {
		OP_BNE   = 4'd0,
		OP_BEQ   = 4'd1,
		OP_BGZ   = 4'd2,
		OP_BLZ   = 4'd3,
		OP_ADI   = 4'd4,
		OP_ORI   = 4'd5,
		OP_LHI   = 4'd6,
		OP_LWD   = 4'd7,
		OP_SWD   = 4'd8,
		OP_JMP   = 4'd9,
		OP_JAL   = 4'd10,
		OP_RTYPE = 4'd15
	} opcodeT;

	typedef enum logic [5:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_NOT = 6'd4,
		FN_TCP = 6'd5,
		FN_SHL = 6'd6,
		FN_SHR = 6'd7,
		FN_JPR = 6'd25,
		FN_JRL = 6'd26,
		FN_WWD = 6'd28,
		FN_HLT = 6'd29
	} funcT;

	// ********************
	// ALU operations, same order as the ALU function codes
	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_ORR, ALU_NOT, ALU_TCP, ALU_SHL, ALU_SHR
	} aluOpT;

endpackage

// File: common/cpuPkg.sv
package cpuPkg;

	// instruction sequencing
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_FETCH,
		ST_DECODE,
		ST_EXECUTE,
		ST_MEMORY,
		ST_WRITEBACK,
		ST_HALTED
	} stageT;

	// where the next PC comes from
	typedef enum logic [1:0] {
		PC_SEQ,     // PC+1
		PC_JUMP,    // 12-bit target
		PC_REG,     // rs
		PC_BRANCH   // PC+1 plus offset when taken
	} pcSrcT;

endpackage

// File: hdl/alu.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module alu (
	input  logic [`WORD_SIZE-1:0] a,
	input  logic [`WORD_SIZE-1:0] b,
	input  isaPkg::aluOpT         op,
	output logic [`WORD_SIZE-1:0] result
);
	import isaPkg::*;

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;    // also pass-B with a at zero
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_ORR: result = a | b;
			ALU_NOT: result = ~a;
			ALU_TCP: result = ~a + `WORD_SIZE'(1);
			ALU_SHL: result = a << 1;
			ALU_SHR: result = $signed(a) >>> 1;  // sign bit kept
			default: result = a + b;
		endcase
	end

endmodule

// File: hdl/registerFile.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module registerFile (
	input  logic                         clk,
	input  logic                         arstN,
	input  logic [$clog2(`NUM_REGS)-1:0] readA,
	input  logic [$clog2(`NUM_REGS)-1:0] readB,
	input  logic [$clog2(`NUM_REGS)-1:0] writeIdx,
	input  logic [`WORD_SIZE-1:0]        writeData,
	input  logic                         writeEn,
	output logic [`WORD_SIZE-1:0]        dataA,
	output logic [`WORD_SIZE-1:0]        dataB
);
	logic [`WORD_SIZE-1:0] regs [`NUM_REGS];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else if (writeEn) begin
			regs[writeIdx] <= writeData;
		end
	end

	// read ports see a write only after the edge
	assign dataA = regs[readA];
	assign dataB = regs[readB];

endmodule

// File: cpu/controlUnit.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module controlUnit (
	input  logic                  clk,
	input  logic                  arstN,
	input  logic [`WORD_SIZE-1:0] instruction,
	input  logic                  decodeEn,
	output cpuPkg::pcSrcT         pcSrc,
	output logic                  regWrite,
	output logic                  aluSrcB,
	output logic                  memWrite,
	output logic                  memRead,
	output logic                  memToReg,
	output isaPkg::aluOpT         aluOp,
	output logic                  branchOp,
	output logic                  isLink,
	output logic                  isWwd,
	output logic                  isHalt,
	output logic                  rType,
	output logic                  iType,
	output logic                  jType
);
	import isaPkg::*;
	import cpuPkg::*;

	opcodeT opcode;
	funcT   func;

	assign opcode = opcodeT'(instruction[15:12]);
	assign func   = funcT'(instruction[5:0]);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pcSrc    <= PC_SEQ;
			regWrite <= 1'b0;
			aluSrcB  <= 1'b0;
			memWrite <= 1'b0;
			memRead  <= 1'b0;
			memToReg <= 1'b0;
			aluOp    <= ALU_ADD;
			branchOp <= 1'b0;
			isLink   <= 1'b0;
			isWwd    <= 1'b0;
			isHalt   <= 1'b0;
			rType    <= 1'b0;
			iType    <= 1'b0;
			jType    <= 1'b0;
		end else if (decodeEn) begin
			// start from a no-op, the tables below override
			pcSrc    <= PC_SEQ;
			regWrite <= 1'b0;
			aluSrcB  <= 1'b0;
			memWrite <= 1'b0;
			memRead  <= 1'b0;
			memToReg <= 1'b0;
			aluOp    <= ALU_ADD;
			branchOp <= 1'b0;
			isLink   <= 1'b0;
			isWwd    <= 1'b0;
			isHalt   <= 1'b0;
			rType    <= 1'b0;
			iType    <= 1'b0;
			jType    <= 1'b0;

			case (opcode)
				OP_RTYPE: begin
					rType <= 1'b1;
					// ********************
					// function table
					case (func)
						FN_ADD, FN_SUB, FN_AND, FN_ORR,
						FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
							regWrite <= 1'b1;
							aluOp    <= aluOpT'(func[2:0]); // low func bits are the ALU code
						end
						FN_JPR: pcSrc <= PC_REG;
						FN_JRL: begin
							pcSrc    <= PC_REG;
							regWrite <= 1'b1;
							isLink   <= 1'b1;
						end
						FN_WWD: isWwd <= 1'b1;
						FN_HLT: isHalt <= 1'b1;
						default: ;
					endcase
				end
				// ********************
				// opcode table
				OP_ADI, OP_LHI: begin
					regWrite <= 1'b1;
					aluSrcB  <= 1'b1;
					iType    <= 1'b1;
				end
				OP_ORI: begin
					regWrite <= 1'b1;
					aluSrcB  <= 1'b1;
					aluOp    <= ALU_ORR;
					iType    <= 1'b1;
				end
				OP_LWD: begin
					regWrite <= 1'b1;
					aluSrcB  <= 1'b1;
					memRead  <= 1'b1;
					memToReg <= 1'b1;
					iType    <= 1'b1;
				end
				OP_SWD: begin
					aluSrcB  <= 1'b1;
					memWrite <= 1'b1;
					iType    <= 1'b1;
				end
				OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: begin
					pcSrc    <= PC_BRANCH;
					branchOp <= 1'b1;
					iType    <= 1'b1;
				end
				OP_JMP: begin
					pcSrc <= PC_JUMP;
					jType <= 1'b1;
				end
				OP_JAL: begin
					pcSrc    <= PC_JUMP;
					regWrite <= 1'b1;
					isLink   <= 1'b1;
					jType    <= 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

// File: cpu/datapath.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module datapath (
	input  logic                            clk,
	input  logic                            arstN,
	input  logic [`WORD_SIZE-1:0]           dataIn,
	input  logic                            inputReady,
	input  cpuPkg::pcSrcT                   pcSrc,
	input  logic                            regWrite,
	input  logic                            aluSrcB,
	input  logic                            memWrite,
	input  logic                            memRead,
	input  logic                            memToReg,
	input  isaPkg::aluOpT                   aluOp,
	input  logic                            branchOp,
	input  logic                            isLink,
	input  logic                            isWwd,
	input  logic                            isHalt,
	input  logic                            rType,
	input  logic                            iType,
	input  logic                            jType,
	input  logic [`WORD_SIZE-1:0]           aluResult,
	input  logic [`WORD_SIZE-1:0]           regDataA,
	input  logic [`WORD_SIZE-1:0]           regDataB,
	output logic [`WORD_SIZE-1:0]           address,
	output logic [`WORD_SIZE-1:0]           dataOut,
	output logic                            readM,
	output logic                            writeM,
	output logic [`WORD_SIZE-1:0]           instruction,
	output logic                            decodeEn,
	output logic [`WORD_SIZE-1:0]           aluA,
	output logic [`WORD_SIZE-1:0]           aluB,
	output isaPkg::aluOpT                   aluSel,
	output logic [$clog2(`NUM_REGS)-1:0]    regReadA,
	output logic [$clog2(`NUM_REGS)-1:0]    regReadB,
	output logic [$clog2(`NUM_REGS)-1:0]    regWriteIdx,
	output logic [`WORD_SIZE-1:0]           regWriteData,
	output logic                            regWriteEn,
	output logic [`WORD_SIZE-1:0]           outputPort,
	output logic                            wwdValid,
	output logic [`WORD_SIZE-1:0]           numInst,
	output logic                            isHalted
);
	import isaPkg::*;
	import cpuPkg::*;

	localparam int IDX_W = $clog2(`NUM_REGS);

	stageT                 stage;
	opcodeT                opcode;
	logic [`WORD_SIZE-1:0] pc;
	logic [`WORD_SIZE-1:0] ir;
	logic [`WORD_SIZE-1:0] mdr;
	logic [`WORD_SIZE-1:0] aluOut;
	logic [`WORD_SIZE-1:0] nextPc;
	logic [`WORD_SIZE-1:0] pcPlus1;
	logic [`WORD_SIZE-1:0] immExt;
	logic [`WORD_SIZE-1:0] jumpTarget;
	logic [`WORD_SIZE-1:0] pcSel;
	logic                  taken;

	assign opcode  = opcodeT'(ir[15:12]);
	assign pcPlus1 = pc + `WORD_SIZE'(1);

	// ********************
	// stage sequencer
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			stage <= ST_IDLE;
		end else begin
			case (stage)
				ST_IDLE:      stage <= ST_FETCH;
				ST_FETCH:     if (inputReady) stage <= ST_DECODE;
				ST_DECODE:    stage <= ST_EXECUTE;
				ST_EXECUTE:   stage <= (memRead || memWrite) ? ST_MEMORY : ST_WRITEBACK;
				ST_MEMORY:    if (inputReady) stage <= ST_WRITEBACK;
				ST_WRITEBACK: stage <= isHalt ? ST_HALTED : ST_FETCH;
				default:      ; // halted until reset
			endcase
		end
	end

	assign decodeEn    = (stage == ST_DECODE);
	assign isHalted    = (stage == ST_HALTED);
	assign instruction = ir;

	// memory port, strobes held while waiting for inputReady
	assign readM   = (stage == ST_FETCH) || (stage == ST_MEMORY && memRead);
	assign writeM  = (stage == ST_MEMORY) && memWrite;
	assign address = (stage == ST_FETCH) ? pc : aluOut;
	assign dataOut = regDataB;                              // rt

	always_ff @(posedge clk) begin
		if (stage == ST_FETCH && inputReady)
			ir <= dataIn;
		if (stage == ST_MEMORY && inputReady)
			mdr <= dataIn;
		if (stage == ST_EXECUTE) begin
			aluOut <= aluResult;
			nextPc <= pcSel;
		end
		if (stage == ST_WRITEBACK && isWwd)
			outputPort <= regDataA;
	end

	// ********************
	// operands
	always_comb begin
		case (opcode)
			OP_ORI:  immExt = {8'h00, ir[7:0]};
			OP_LHI:  immExt = {ir[7:0], 8'h00};
			default: immExt = {{8{ir[7]}}, ir[7:0]};
		endcase
	end

	assign regReadA = ir[11:10];                            // rs
	assign regReadB = ir[9:8];                              // rt
	assign aluA     = (opcode == OP_LHI) ? '0 : regDataA;   // LHI passes B through ADD
	assign aluB     = (aluSrcB && iType) ? immExt : regDataB;
	assign aluSel   = aluOp;

	// branch decision and next PC
	always_comb begin
		case (opcode)
			OP_BNE:  taken = (regDataA != regDataB);
			OP_BEQ:  taken = (regDataA == regDataB);
			OP_BGZ:  taken = ($signed(regDataA) > 0);
			OP_BLZ:  taken = ($signed(regDataA) < 0);
			default: taken = 1'b0;
		endcase
	end

	assign jumpTarget = jType ? {pc[15:12], ir[11:0]} : regDataA;

	always_comb begin
		case (pcSrc)
			PC_JUMP, PC_REG: pcSel = jumpTarget;
			PC_BRANCH:       pcSel = (branchOp && taken) ? pcPlus1 + immExt : pcPlus1;
			default:         pcSel = pcPlus1;
		endcase
	end

	// ********************
	// write-back and retire
	assign regWriteEn  = (stage == ST_WRITEBACK) && regWrite;
	assign regWriteIdx = isLink ? IDX_W'(`LINK_REG) : (rType ? ir[7:6] : ir[9:8]);

	always_comb begin
		if (isLink)
			regWriteData = pcPlus1;
		else if (memToReg)
			regWriteData = mdr;
		else
			regWriteData = aluOut;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc       <= `RESET_PC;
			numInst  <= '0;
			wwdValid <= 1'b0;
		end else begin
			wwdValid <= 1'b0;
			if (stage == ST_WRITEBACK) begin
				pc       <= nextPc;
				numInst  <= numInst + `WORD_SIZE'(1);
				wwdValid <= isWwd;                  // one-cycle pulse
			end
		end
	end

endmodule

// File: cpu/cpu.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module cpu (
	input  logic                  clk,
	input  logic                  arstN,
	output logic [`WORD_SIZE-1:0] address,
	output logic [`WORD_SIZE-1:0] dataOut,
	input  logic [`WORD_SIZE-1:0] dataIn,
	output logic                  readM,
	output logic                  writeM,
	input  logic                  inputReady,
	output logic [`WORD_SIZE-1:0] outputPort,
	output logic                  wwdValid,
	output logic [`WORD_SIZE-1:0] numInst,
	output logic                  isHalted
);
	import isaPkg::*;
	import cpuPkg::*;

	localparam int IDX_W = $clog2(`NUM_REGS);

	// controller <-> datapath
	logic [`WORD_SIZE-1:0] instruction;
	logic                  decodeEn;
	pcSrcT                 pcSrc;
	logic                  regWrite;
	logic                  aluSrcB;
	logic                  memWrite;
	logic                  memRead;
	logic                  memToReg;
	aluOpT                 aluOp;
	logic                  branchOp;
	logic                  isLink;
	logic                  isWwd;
	logic                  isHalt;
	logic                  rType;
	logic                  iType;
	logic                  jType;

	// datapath <-> alu / register file
	aluOpT                 aluSel;
	logic [`WORD_SIZE-1:0] aluA;
	logic [`WORD_SIZE-1:0] aluB;
	logic [`WORD_SIZE-1:0] aluResult;
	logic [IDX_W-1:0]      regReadA;
	logic [IDX_W-1:0]      regReadB;
	logic [IDX_W-1:0]      regWriteIdx;
	logic [`WORD_SIZE-1:0] regWriteData;
	logic                  regWriteEn;
	logic [`WORD_SIZE-1:0] regDataA;
	logic [`WORD_SIZE-1:0] regDataB;

	controlUnit uCtrl (.*);

	datapath uDatapath (.*);

	alu uAlu (
		.a      (aluA),
		.b      (aluB),
		.op     (aluSel),
		.result (aluResult)
	);

	registerFile uRegs (
		.clk       (clk),
		.arstN     (arstN),
		.readA     (regReadA),
		.readB     (regReadB),
		.writeIdx  (regWriteIdx),
		.writeData (regWriteData),
		.writeEn   (regWriteEn),
		.dataA     (regDataA),
		.dataB     (regDataB)
	);

endmodule

// File: sim/clockGen.sv
`timescale 1ns/10ps

module clockGen (
	output logic clk,
	output logic arstN
);
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;  // 10 ns period
	end

	initial begin
		arstN = 1'b0;
		repeat (8) @(posedge clk);
		#1 arstN = 1'b1;        // release just after the 8th edge
	end

endmodule

// File: sim/tbMemory.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module tbMemory #(
	parameter int SEED = 1
) (
	input  logic                  clk,
	input  logic                  arstN,
	input  logic [`WORD_SIZE-1:0] address,
	input  logic [`WORD_SIZE-1:0] dataOut,
	input  logic                  readM,
	input  logic                  writeM,
	output logic [`WORD_SIZE-1:0] dataIn,
	output logic                  inputReady
);
	logic [`WORD_SIZE-1:0] mem [1 << `WORD_SIZE];
	logic                  pending;
	int                    waitLeft;

	function automatic void clearAll();
		for (int i = 0; i < (1 << `WORD_SIZE); i++)
			mem[i] = '0;
	endfunction

	function automatic void storeWord(input logic [`WORD_SIZE-1:0] addr,
			input logic [`WORD_SIZE-1:0] data);
		mem[addr] = data;
	endfunction

	function automatic logic [`WORD_SIZE-1:0] readWord(input logic [`WORD_SIZE-1:0] addr);
		return mem[addr];
	endfunction

	// ********************
	// request handling, outputs change 1 ns after the edge
	initial begin
		void'($urandom(SEED));
		dataIn     = '0;
		inputReady = 1'b0;
		pending    = 1'b0;
		waitLeft   = 0;
		forever begin
			@(posedge clk);
			#1;
			inputReady = 1'b0;
			if (!arstN) begin
				pending = 1'b0;
			end else if (readM || writeM) begin
				if (!pending) begin
					pending  = 1'b1;
					waitLeft = $urandom_range(3, 0);  // cycles with ready low
				end
				if (waitLeft == 0) begin
					pending    = 1'b0;
					inputReady = 1'b1;
					if (writeM)
						mem[address] = dataOut;
					else
						dataIn = mem[address];
				end else begin
					waitLeft--;
				end
			end
		end
	end

endmodule

// File: sim/cpuTb.sv
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module cpuTb;
	import isaPkg::*;

	logic                  clk;
	logic                  arstN;
	logic [`WORD_SIZE-1:0] address;
	logic [`WORD_SIZE-1:0] dataOut;
	logic [`WORD_SIZE-1:0] dataIn;
	logic                  readM;
	logic                  writeM;
	logic                  inputReady;
	logic [`WORD_SIZE-1:0] outputPort;
	logic                  wwdValid;
	logic [`WORD_SIZE-1:0] numInst;
	logic                  isHalted;

	logic [`WORD_SIZE-1:0] progWords [$];
	logic [`WORD_SIZE-1:0] expectOut [$];
	logic [`WORD_SIZE-1:0] expectMemAddr [$];
	logic [`WORD_SIZE-1:0] expectMemData [$];
	logic [`WORD_SIZE-1:0] expectRetired;
	logic                  expectHalted;
	logic                  strobeAfterHalt = 1'b0;
	int                    wwdTotal = 0;
	int                    passCount = 0;
	int                    failCount = 0;
	int                    cycles = 0;
	int                    timeLimit = 100000;

	clockGen uClk (
		.clk   (clk),
		.arstN (arstN)
	);

	tbMemory #(.SEED(14)) uMem (
		.clk        (clk),
		.arstN      (arstN),
		.address    (address),
		.dataOut    (dataOut),
		.readM      (readM),
		.writeM     (writeM),
		.dataIn     (dataIn),
		.inputReady (inputReady)
	);

	cpu u_dut (.*);

	// ********************
	// instruction encoding
	function automatic logic [`WORD_SIZE-1:0] immInstr(opcodeT op, int rs, int rt, int imm);
		return {op, 2'(rs), 2'(rt), 8'(imm)};
	endfunction

	function automatic logic [`WORD_SIZE-1:0] regInstr(int rs, int rt, int rd, funcT fn);
		return {OP_RTYPE, 2'(rs), 2'(rt), 2'(rd), fn};
	endfunction

	function automatic logic [`WORD_SIZE-1:0] jumpInstr(opcodeT op, int target);
		return {op, 12'(target)};
	endfunction

	task automatic buildProgram();
		progWords.push_back(immInstr(OP_LHI, 0, 1, 8'h12));   // 0  r1 = 1200
		progWords.push_back(regInstr(1, 0, 0, FN_WWD));
		progWords.push_back(immInstr(OP_ADI, 0, 0, -3));      // 2  r0 = fffd
		progWords.push_back(regInstr(0, 0, 0, FN_WWD));
		progWords.push_back(immInstr(OP_ORI, 1, 2, 8'hf0));   // 4  r2 = 12f0
		progWords.push_back(regInstr(2, 0, 0, FN_WWD));
		progWords.push_back(immInstr(OP_ADI, 1, 1, 8'h34));   // 6  r1 = 1234
		progWords.push_back(immInstr(OP_LHI, 0, 3, 8'h0f));
		progWords.push_back(immInstr(OP_ORI, 3, 3, 8'h0f));   // 8  r3 = 0f0f
		// r2 = r1 op r3, each shown by WWD
		progWords.push_back(regInstr(1, 3, 2, FN_ADD));       // 9
		progWords.push_back(regInstr(2, 0, 0, FN_WWD));
		progWords.push_back(regInstr(1, 3, 2, FN_SUB));
		progWords.push_back(regInstr(2, 0, 0, FN_WWD));
		progWords.push_back(regInstr(1, 3, 2, FN_AND));
		progWords.push_back(regInstr(2, 0, 0, FN_WWD));
		progWords.push_back(regInstr(1, 3, 2, FN_ORR));
		progWords.push_back(regInstr(2, 0, 0, FN_WWD));
		progWords.push_back(regInstr(1, 3, 2, FN_NOT));
		progWords.push_back(regInstr(2, 0, 0, FN_WWD));
		progWords.push_back(regInstr(1, 3, 2, FN_TCP));
		progWords.push_back(regInstr(2, 0, 0, FN_WWD));
		progWords.push_back(regInstr(1, 3, 2, FN_SHL));
		progWords.push_back(regInstr(2, 0, 0, FN_WWD));
		progWords.push_back(regInstr(0, 3, 2, FN_SHR));       // 23 negative source
		progWords.push_back(regInstr(2, 0, 0, FN_WWD));
		progWords.push_back(immInstr(OP_SWD, 3, 1, 8'h11));   // 25 [0f20] = r1
		progWords.push_back(immInstr(OP_LWD, 3, 2, 8'h11));   // r2 = [0f20]
		progWords.push_back(regInstr(2, 0, 0, FN_WWD));
		// branches skip a WWD r3 marker when taken
		progWords.push_back(immInstr(OP_BNE, 1, 2, 1));       // 28 not taken
		progWords.push_back(regInstr(0, 0, 0, FN_WWD));
		progWords.push_back(immInstr(OP_BNE, 1, 3, 1));       // 30 taken
		progWords.push_back(regInstr(3, 0, 0, FN_WWD));
		progWords.push_back(immInstr(OP_BEQ, 1, 2, 1));       // 32 taken
		progWords.push_back(regInstr(3, 0, 0, FN_WWD));
		progWords.push_back(immInstr(OP_BEQ, 1, 3, 1));       // 34 not taken
		progWords.push_back(regInstr(1, 0, 0, FN_WWD));
		progWords.push_back(immInstr(OP_BGZ, 1, 0, 1));       // 36 taken
		progWords.push_back(regInstr(3, 0, 0, FN_WWD));
		progWords.push_back(immInstr(OP_BGZ, 0, 0, 1));       // 38 not taken
		progWords.push_back(regInstr(0, 0, 0, FN_WWD));
		progWords.push_back(immInstr(OP_BLZ, 0, 0, 1));       // 40 taken
		progWords.push_back(regInstr(3, 0, 0, FN_WWD));
		progWords.push_back(immInstr(OP_BLZ, 1, 0, 1));       // 42 not taken
		progWords.push_back(regInstr(1, 0, 0, FN_WWD));
		// jumps and links
		progWords.push_back(jumpInstr(OP_JMP, 46));           // 44
		progWords.push_back(regInstr(3, 0, 0, FN_WWD));
		progWords.push_back(jumpInstr(OP_JAL, 48));           // 46 r2 = 47
		progWords.push_back(regInstr(3, 0, 0, FN_WWD));
		progWords.push_back(regInstr(2, 0, 0, FN_WWD));       // 48
		progWords.push_back(immInstr(OP_LHI, 0, 0, 0));
		progWords.push_back(immInstr(OP_ADI, 0, 0, 53));      // 50 r0 = 53
		progWords.push_back(regInstr(0, 0, 0, FN_JPR));
		progWords.push_back(regInstr(3, 0, 0, FN_WWD));
		progWords.push_back(immInstr(OP_ADI, 0, 1, 4));       // 53 r1 = 57
		progWords.push_back(regInstr(1, 0, 0, FN_JRL));       // 54 r2 = 55
		progWords.push_back(regInstr(3, 0, 0, FN_WWD));
		progWords.push_back(regInstr(3, 0, 0, FN_WWD));
		progWords.push_back(regInstr(2, 0, 0, FN_WWD));       // 57
		progWords.push_back(regInstr(0, 0, 0, FN_HLT));       // 58
	endtask

	task automatic buildExpected();
		expectOut = '{16'h1200, 16'hfffd, 16'h12f0,
			16'h2143, 16'h0325, 16'h0204, 16'h1f3f,       // add sub and orr
			16'hedcb, 16'hedcc, 16'h2468, 16'hfffe,       // not tcp shl shr
			16'h1234,                                     // load after store
			16'hfffd, 16'h1234, 16'hfffd, 16'h1234,       // not-taken paths
			16'h002f, 16'h0037};                          // link values
		expectMemAddr.push_back(16'h0f20);
		expectMemData.push_back(16'h1234);
		expectRetired = 16'd50;  // 59 words minus 9 skipped
		expectHalted  = 1'b1;
	endtask

	// ********************
	// checks
	task automatic checkWord(input logic [`WORD_SIZE-1:0] got, input logic [`WORD_SIZE-1:0] exp,
			input string what);
		if (got === exp) begin
			passCount++;
			$display("ok      %s = %h", what, got);
		end else begin
			failCount++;
			$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkCount(input logic [`WORD_SIZE-1:0] got,
			input logic [`WORD_SIZE-1:0] exp, input string what);
		if (got === exp) begin
			passCount++;
			$display("ok      %s = %0d", what, got);
		end else begin
			failCount++;
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got === exp) begin
			passCount++;
			$display("ok      %s = %b", what, got);
		end else begin
			failCount++;
			$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	always @(negedge clk) begin
		if (isHalted && (readM || writeM))
			strobeAfterHalt = 1'b1;
		if (wwdValid)
			wwdTotal++;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > timeLimit) begin
			$display("timeout: the CPU did not halt within %0d cycles", timeLimit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		buildProgram();
		buildExpected();
		timeLimit = 40 * progWords.size();
		uMem.clearAll();
		foreach (progWords[i])
			uMem.storeWord(`WORD_SIZE'(i), progWords[i]);
		wait (arstN === 1'b1);

		foreach (expectOut[i]) begin
			do @(negedge clk); while (!wwdValid && !isHalted);
			if (wwdValid) begin
				checkWord(outputPort, expectOut[i], $sformatf("WWD output %0d", i));
			end else begin
				failCount++;
				$display("the CPU halted before WWD output %0d appeared", i);
			end
		end

		do @(negedge clk); while (!isHalted);
		repeat (10) @(negedge clk);            // watch the bus while halted
		checkFlag(isHalted, expectHalted, "halted state");
		checkFlag(strobeAfterHalt, 1'b0, "memory strobe after HLT");
		checkCount(numInst, expectRetired, "retired instructions");
		checkCount(`WORD_SIZE'(wwdTotal), `WORD_SIZE'(expectOut.size()), "WWD pulses");
		foreach (expectMemAddr[i])
			checkWord(uMem.readWord(expectMemAddr[i]), expectMemData[i],
				$sformatf("memory word at %h", expectMemAddr[i]));

		$display("checks passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: list.f
+incdir+common
common/isaPkg.sv
common/cpuPkg.sv
hdl/alu.sv
hdl/registerFile.sv
cpu/controlUnit.sv
cpu/datapath.sv
cpu/cpu.sv
sim/clockGen.sv
sim/tbMemory.sv
sim/cpuTb.sv

// File: Makefile
SOURCES := list.f $(wildcard common/*.sv common/*.svh cpu/*.sv hdl/*.sv sim/*.sv)

obj_dir/VcpuTb: $(SOURCES)
	verilator --binary --timing -Wno-fatal --top-module cpuTb -f list.f

.PHONY: run clean

run: obj_dir/VcpuTb
	@out="$$(./obj_dir/VcpuTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
